//--- accel_ctrl.sv
module accel_ctrl
  import accel_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              start_i,
  input  logic [WORD_W-1:0] src_i,
  input  logic [WORD_W-1:0] dst_i,
  input  logic [WORD_W-1:0] len_i,
  input  logic              rd_cmd_ready_i,
  input  logic              res_valid_i,
  input  logic [WORD_W-1:0] res_data_i,
  input  logic              wr_cmd_ready_i,
  input  logic              wr_beat_ready_i,
  input  logic              burst_done_i,
  output logic              busy_o,
  output logic              rd_cmd_valid_o,
  output logic [WORD_W-1:0] rd_cmd_addr_o,
  output logic [BEAT_W-1:0] rd_cmd_beats_o,
  output logic              wr_cmd_valid_o,
  output logic [WORD_W-1:0] wr_cmd_addr_o,
  output logic [BEAT_W-1:0] wr_cmd_beats_o,
  output logic [WORD_W-1:0] wr_beat_data_o
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_READ,     // issue read burst for the next chunk
    S_COLLECT,  // wait for all results in the buffer
    S_WRITE,    // issue write burst
    S_WAIT      // drain buffer until write burst answered
  } state_t;

  state_t            state_q;
  logic [WORD_W-1:0] src_q;
  logic [WORD_W-1:0] dst_q;
  logic [WORD_W-1:0] remain_q;
  logic [BEAT_W-1:0] chunk_q;
  logic [BEAT_W-1:0] chunk_w;
  logic [WORD_W-1:0] step_w;
  logic [BEAT_W-1:0] fill_q;
  logic [BEAT_W-1:0] drain_q;
  logic [WORD_W-1:0] chunk_buf [BURST_LEN];

  assign chunk_w = (remain_q >= BURST_LEN) ? BEAT_W'(BURST_LEN) : remain_q[BEAT_W-1:0];
  assign step_w  = WORD_W'(chunk_q) << 2;  // bytes covered by this chunk

  assign busy_o         = (state_q != S_IDLE);
  assign rd_cmd_valid_o = (state_q == S_READ) && (remain_q != '0);
  assign rd_cmd_addr_o  = src_q;
  assign rd_cmd_beats_o = chunk_w;
  assign wr_cmd_valid_o = (state_q == S_WRITE);
  assign wr_cmd_addr_o  = dst_q;
  assign wr_cmd_beats_o = chunk_q;
  assign wr_beat_data_o = chunk_buf[drain_q[PTR_W-1:0]];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q  <= S_IDLE;
      src_q    <= '0;
      dst_q    <= '0;
      remain_q <= '0;
      chunk_q  <= '0;
      fill_q   <= '0;
      drain_q  <= '0;
    end else begin
      if (res_valid_i) fill_q <= fill_q + 1'b1;
      if (wr_beat_ready_i) drain_q <= drain_q + 1'b1;
      case (state_q)
        S_IDLE: if (start_i) begin
          src_q    <= src_i;
          dst_q    <= dst_i;
          remain_q <= len_i;
          state_q  <= S_READ;
        end
        S_READ: begin
          if (remain_q == '0) state_q <= S_IDLE;  // job complete
          else if (rd_cmd_ready_i) begin
            chunk_q <= chunk_w;
            fill_q  <= '0;
            state_q <= S_COLLECT;
          end
        end
        S_COLLECT: if (fill_q == chunk_q) begin
          drain_q <= '0;
          state_q <= S_WRITE;
        end
        S_WRITE: if (wr_cmd_ready_i) state_q <= S_WAIT;
        S_WAIT: if (burst_done_i) begin
          src_q    <= src_q + step_w;
          dst_q    <= dst_q + step_w;
          remain_q <= remain_q - WORD_W'(chunk_q);
          state_q  <= S_READ;
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (res_valid_i) chunk_buf[fill_q[PTR_W-1:0]] <= res_data_i;
  end

endmodule

//--- accel_pkg.sv
package accel_pkg;

  // data path and bus widths
  localparam int WORD_W = 32;
  localparam int BE_W   = WORD_W / 8;  // byte enables per word
  localparam int OFF_W  = 8;           // register offset bits taken from the address

  // burst shaping
  localparam int BURST_LEN = 8;                    // max beats per burst, chunk buffer depth
  localparam int BEAT_W    = 4;                    // holds 0..BURST_LEN
  localparam int PTR_W     = $clog2(BURST_LEN);    // chunk buffer index

  // host side request window
  localparam int MAX_OUTSTANDING = 2;
  localparam int OUT_W           = $clog2(MAX_OUTSTANDING + 1);

  // register map, byte offsets
  localparam logic [OFF_W-1:0] REG_CTRL   = 8'h00;  // bit 0 start, write only
  localparam logic [OFF_W-1:0] REG_STATUS = 8'h04;  // bit 0 busy, bit 1 done
  localparam logic [OFF_W-1:0] REG_SRC    = 8'h08;
  localparam logic [OFF_W-1:0] REG_DST    = 8'h0C;
  localparam logic [OFF_W-1:0] REG_LEN    = 8'h10;  // job length in words
  localparam logic [OFF_W-1:0] REG_SCALE  = 8'h14;
  localparam logic [OFF_W-1:0] REG_BIAS   = 8'h18;

  // status bit positions
  localparam int STAT_BUSY = 0;
  localparam int STAT_DONE = 1;

endpackage

//--- accel_stim.txt
# R <offset> <wdata> <byte enables> <expected readback>, X <offset> for an unmapped access
# D <name> <src> <dst> <len> <scale> <bias>, all numbers in hex
R 08 12345678 f 12345678
R 08 aabbccdd 2 1234cc78
R 08 aabbccdd 9 aa34ccdd
R 14 0000ffff 3 0000ffff
R 14 11223344 c 1122ffff
R 0c 00c0ffee f 00c0ffee
R 00 00000000 f 00000000
R 04 ffffffff f 00000000
X 1c
X 09
X 80
D two_bursts 00001000 00002000 10 00000003 00000007
D wrap_remainder 00003000 00004000 b 9e3779b9 deadbeef
D empty_job 00005000 00006000 0 00000005 00000001
D after_empty 00007000 00008000 5 00000002 00000001

//--- burst_to_host.sv
module burst_to_host
  import accel_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              rd_cmd_valid_i,
  input  logic [WORD_W-1:0] rd_cmd_addr_i,
  input  logic [BEAT_W-1:0] rd_cmd_beats_i,
  input  logic              wr_cmd_valid_i,
  input  logic [WORD_W-1:0] wr_cmd_addr_i,
  input  logic [BEAT_W-1:0] wr_cmd_beats_i,
  input  logic [WORD_W-1:0] wr_beat_data_i,
  input  logic              host_gnt_i,
  input  logic              host_rvalid_i,
  input  logic              host_err_i,
  input  logic [WORD_W-1:0] host_rdata_i,
  output logic              rd_cmd_ready_o,
  output logic              rd_beat_valid_o,
  output logic [WORD_W-1:0] rd_beat_data_o,
  output logic              wr_cmd_ready_o,
  output logic              wr_beat_ready_o,
  output logic              burst_done_o,
  output logic              host_req_o,
  output logic [WORD_W-1:0] host_addr_o,
  output logic              host_we_o,
  output logic [BE_W-1:0]   host_be_o,
  output logic [WORD_W-1:0] host_wdata_o
);

  logic              active_q;
  logic              is_wr_q;
  logic [WORD_W-1:0] addr_q;
  logic [BEAT_W-1:0] issue_left_q;   // word requests still to send
  logic [BEAT_W-1:0] answer_left_q;  // responses still expected
  logic [OUT_W-1:0]  outstanding_q;
  logic              rd_accept;
  logic              wr_accept;
  logic              issue;
  logic              resp;

  assign rd_cmd_ready_o = !active_q;
  assign wr_cmd_ready_o = !active_q && !rd_cmd_valid_i;  // reads win a tie
  assign rd_accept      = rd_cmd_valid_i && rd_cmd_ready_o;
  assign wr_accept      = wr_cmd_valid_i && wr_cmd_ready_o;

  // request held steady until granted, outstanding can only drop meanwhile
  assign host_req_o   = active_q && (issue_left_q != '0) && (outstanding_q < MAX_OUTSTANDING);
  assign host_addr_o  = addr_q;
  assign host_we_o    = is_wr_q;
  assign host_be_o    = '1;
  assign host_wdata_o = wr_beat_data_i;  // buffer entry shown combinationally

  assign issue           = host_req_o && host_gnt_i;
  assign resp            = active_q && (host_rvalid_i || host_err_i);  // errors still end a word
  assign wr_beat_ready_o = issue && is_wr_q;  // advance drain pointer on grant

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      active_q      <= 1'b0;
      is_wr_q       <= 1'b0;
      addr_q        <= '0;
      issue_left_q  <= '0;
      answer_left_q <= '0;
      outstanding_q <= '0;
    end else begin
      if (rd_accept || wr_accept) begin
        active_q      <= 1'b1;
        is_wr_q       <= wr_accept;
        addr_q        <= wr_accept ? wr_cmd_addr_i : rd_cmd_addr_i;
        issue_left_q  <= wr_accept ? wr_cmd_beats_i : rd_cmd_beats_i;
        answer_left_q <= wr_accept ? wr_cmd_beats_i : rd_cmd_beats_i;
      end else begin
        if (issue) begin
          addr_q       <= addr_q + WORD_W'(4);
          issue_left_q <= issue_left_q - 1'b1;
        end
        if (resp) begin
          answer_left_q <= answer_left_q - 1'b1;
          if (answer_left_q == BEAT_W'(1)) active_q <= 1'b0;  // burst fully answered
        end
      end
      case ({issue, resp})
        2'b10:   outstanding_q <= outstanding_q + 1'b1;
        2'b01:   outstanding_q <= outstanding_q - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      rd_beat_valid_o <= 1'b0;
      burst_done_o    <= 1'b0;
    end else begin
      rd_beat_valid_o <= resp && !is_wr_q;
      burst_done_o    <= resp && is_wr_q && (answer_left_q == BEAT_W'(1));
    end
  end

  always_ff @(posedge clk) begin
    if (resp && !is_wr_q) rd_beat_data_o <= host_rdata_i;
  end

endmodule

//--- cgra_ibex_top.sv
module cgra_ibex_top
  import accel_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n_i,
  // device port, CPU programs the registers
  input  logic              dev_req_i,
  input  logic [WORD_W-1:0] dev_addr_i,
  input  logic              dev_we_i,
  input  logic [BE_W-1:0]   dev_be_i,
  input  logic [WORD_W-1:0] dev_wdata_i,
  output logic              dev_gnt_o,
  output logic              dev_rvalid_o,
  output logic              dev_err_o,
  output logic [WORD_W-1:0] dev_rdata_o,
  // host port to system memory
  output logic              host_req_o,
  output logic [WORD_W-1:0] host_addr_o,
  output logic              host_we_o,
  output logic [BE_W-1:0]   host_be_o,
  output logic [WORD_W-1:0] host_wdata_o,
  input  logic              host_gnt_i,
  input  logic              host_rvalid_i,
  input  logic              host_err_i,
  input  logic [WORD_W-1:0] host_rdata_i
);

  logic              start, busy;
  logic [WORD_W-1:0] src, dst, len, scale, bias;
  logic              rd_cmd_valid, rd_cmd_ready, wr_cmd_valid, wr_cmd_ready;
  logic [WORD_W-1:0] rd_cmd_addr, wr_cmd_addr;
  logic [BEAT_W-1:0] rd_cmd_beats, wr_cmd_beats;
  logic              rd_beat_valid, wr_beat_ready, burst_done;
  logic [WORD_W-1:0] rd_beat_data, wr_beat_data;
  logic              res_valid;
  logic [WORD_W-1:0] res_data;

  dev_reg_bridge u_regs (
    .clk, .rst_n_i, .dev_req_i, .dev_addr_i, .dev_we_i, .dev_be_i, .dev_wdata_i,
    .busy_i (busy), .dev_gnt_o, .dev_rvalid_o, .dev_err_o, .dev_rdata_o,
    .start_o (start), .src_o (src), .dst_o (dst), .len_o (len),
    .scale_o (scale), .bias_o (bias)
  );

  accel_ctrl u_ctrl (
    .clk, .rst_n_i, .start_i (start), .src_i (src), .dst_i (dst), .len_i (len),
    .rd_cmd_ready_i (rd_cmd_ready), .res_valid_i (res_valid), .res_data_i (res_data),
    .wr_cmd_ready_i (wr_cmd_ready), .wr_beat_ready_i (wr_beat_ready),
    .burst_done_i (burst_done), .busy_o (busy),
    .rd_cmd_valid_o (rd_cmd_valid), .rd_cmd_addr_o (rd_cmd_addr),
    .rd_cmd_beats_o (rd_cmd_beats), .wr_cmd_valid_o (wr_cmd_valid),
    .wr_cmd_addr_o (wr_cmd_addr), .wr_cmd_beats_o (wr_cmd_beats),
    .wr_beat_data_o (wr_beat_data)
  );

  scale_pe u_pe (
    .clk, .rst_n_i, .in_valid_i (rd_beat_valid), .in_data_i (rd_beat_data),
    .scale_i (scale), .bias_i (bias), .out_valid_o (res_valid), .out_data_o (res_data)
  );

  burst_to_host u_host (
    .clk, .rst_n_i,
    .rd_cmd_valid_i (rd_cmd_valid), .rd_cmd_addr_i (rd_cmd_addr),
    .rd_cmd_beats_i (rd_cmd_beats), .wr_cmd_valid_i (wr_cmd_valid),
    .wr_cmd_addr_i (wr_cmd_addr), .wr_cmd_beats_i (wr_cmd_beats),
    .wr_beat_data_i (wr_beat_data), .host_gnt_i, .host_rvalid_i, .host_err_i,
    .host_rdata_i, .rd_cmd_ready_o (rd_cmd_ready), .rd_beat_valid_o (rd_beat_valid),
    .rd_beat_data_o (rd_beat_data), .wr_cmd_ready_o (wr_cmd_ready),
    .wr_beat_ready_o (wr_beat_ready), .burst_done_o (burst_done),
    .host_req_o, .host_addr_o, .host_we_o, .host_be_o, .host_wdata_o
  );

endmodule

//--- dev_reg_bridge.sv
module dev_reg_bridge
  import accel_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              dev_req_i,
  input  logic [WORD_W-1:0] dev_addr_i,
  input  logic              dev_we_i,
  input  logic [BE_W-1:0]   dev_be_i,
  input  logic [WORD_W-1:0] dev_wdata_i,
  input  logic              busy_i,
  output logic              dev_gnt_o,
  output logic              dev_rvalid_o,
  output logic              dev_err_o,
  output logic [WORD_W-1:0] dev_rdata_o,
  output logic              start_o,
  output logic [WORD_W-1:0] src_o,
  output logic [WORD_W-1:0] dst_o,
  output logic [WORD_W-1:0] len_o,
  output logic [WORD_W-1:0] scale_o,
  output logic [WORD_W-1:0] bias_o
);

  logic [OFF_W-1:0]  offset;
  logic              mapped;
  logic              wr_en;
  logic              busy_any;
  logic              busy_q;
  logic              done_q;
  logic [WORD_W-1:0] rd_word;

  // merge enabled bytes of the new word into the old one
  function automatic logic [WORD_W-1:0] merge_be(input logic [WORD_W-1:0] old_w,
                                                 input logic [WORD_W-1:0] new_w,
                                                 input logic [BE_W-1:0]   be);
    logic [WORD_W-1:0] res;
    res = old_w;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  assign dev_gnt_o = dev_req_i;  // always ready
  assign offset    = dev_addr_i[OFF_W-1:0];
  assign wr_en     = dev_req_i && dev_we_i && mapped;
  assign busy_any  = busy_i | start_o;  // a pending start counts as busy

  always_comb begin
    mapped  = 1'b1;
    rd_word = '0;
    case (offset)
      REG_CTRL:   rd_word = '0;  // start reads back as 0
      REG_STATUS: begin
        rd_word[STAT_BUSY] = busy_any;
        rd_word[STAT_DONE] = done_q;
      end
      REG_SRC:    rd_word = src_o;
      REG_DST:    rd_word = dst_o;
      REG_LEN:    rd_word = len_o;
      REG_SCALE:  rd_word = scale_o;
      REG_BIAS:   rd_word = bias_o;
      default:    mapped = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      src_o   <= '0;
      dst_o   <= '0;
      len_o   <= '0;
      scale_o <= '0;
      bias_o  <= '0;
    end else if (wr_en) begin
      case (offset)
        REG_SRC:   src_o   <= merge_be(src_o, dev_wdata_i, dev_be_i);
        REG_DST:   dst_o   <= merge_be(dst_o, dev_wdata_i, dev_be_i);
        REG_LEN:   len_o   <= merge_be(len_o, dev_wdata_i, dev_be_i);
        REG_SCALE: scale_o <= merge_be(scale_o, dev_wdata_i, dev_be_i);
        REG_BIAS:  bias_o  <= merge_be(bias_o, dev_wdata_i, dev_be_i);
        default: ;  // ctrl and status hold no writable state
      endcase
    end
  end

  // start pulse and sticky done
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      start_o <= 1'b0;
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      start_o <= wr_en && (offset == REG_CTRL) && dev_be_i[0] && dev_wdata_i[0] && !busy_any;
      busy_q  <= busy_i;
      if (start_o) done_q <= 1'b0;
      else if (busy_q && !busy_i) done_q <= 1'b1;  // job just finished
    end
  end

  // response one cycle after the grant
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      dev_rvalid_o <= 1'b0;
      dev_err_o    <= 1'b0;
    end else begin
      dev_rvalid_o <= dev_req_i;
      dev_err_o    <= dev_req_i && !mapped;
    end
  end

  always_ff @(posedge clk) begin
    dev_rdata_o <= rd_word;  // zero for unmapped offsets
  end

endmodule

//--- filelist.f
accel_pkg.sv
dev_reg_bridge.sv
accel_ctrl.sv
scale_pe.sv
burst_to_host.sv
cgra_ibex_top.sv
tb_host_mem.sv
tb_cgra_ibex.sv

//--- scale_pe.sv
module scale_pe
  import accel_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              in_valid_i,
  input  logic [WORD_W-1:0] in_data_i,
  input  logic [WORD_W-1:0] scale_i,
  input  logic [WORD_W-1:0] bias_i,
  output logic              out_valid_o,
  output logic [WORD_W-1:0] out_data_o
);

  logic              prod_valid_q;
  logic [WORD_W-1:0] prod_q;  // low word of x * scale

  // valid bits ride along with the data
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      prod_valid_q <= 1'b0;
      out_valid_o  <= 1'b0;
    end else begin
      prod_valid_q <= in_valid_i;
      out_valid_o  <= prod_valid_q;
    end
  end

  // stage one multiply
  always_ff @(posedge clk) begin
    if (in_valid_i) prod_q <= in_data_i * scale_i;
  end

  // stage two add, wraps mod 2^32
  always_ff @(posedge clk) begin
    if (prod_valid_q) out_data_o <= prod_q + bias_i;
  end

endmodule

//--- tb_cgra_ibex.sv
module tb_cgra_ibex
  import accel_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] DEV_BASE = 32'h1a40_0000;  // only the low 8 bits decode

  logic        clk = 1'b0;
  logic        rst_n;
  logic        dev_req;
  logic [31:0] dev_addr;
  logic        dev_we;
  logic [3:0]  dev_be;
  logic [31:0] dev_wdata;
  logic        dev_gnt;
  logic        dev_rvalid;
  logic        dev_err;
  logic [31:0] dev_rdata;
  logic        host_req;
  logic [31:0] host_addr;
  logic        host_we;
  logic [3:0]  host_be;
  logic [31:0] host_wdata;
  logic        host_gnt;
  logic        host_rvalid;
  logic        host_err;
  logic [31:0] host_rdata;

  string       rec_kind [$];
  string       rec_name [$];
  logic [31:0] rec_val [$];  // five values per record
  logic [31:0] reg_model [5];  // expected SRC..BIAS contents
  logic [31:0] rng;
  int          limit = 500;
  int          cycles = 0;
  int          errors = 0;
  int          tests = 0;
  int          failed = 0;
  bit          ok;

  always #2 clk = ~clk;

  cgra_ibex_top DUT (
    .clk (clk), .rst_n_i (rst_n),
    .dev_req_i (dev_req), .dev_addr_i (dev_addr), .dev_we_i (dev_we), .dev_be_i (dev_be),
    .dev_wdata_i (dev_wdata), .dev_gnt_o (dev_gnt), .dev_rvalid_o (dev_rvalid),
    .dev_err_o (dev_err), .dev_rdata_o (dev_rdata),
    .host_req_o (host_req), .host_addr_o (host_addr), .host_we_o (host_we),
    .host_be_o (host_be), .host_wdata_o (host_wdata), .host_gnt_i (host_gnt),
    .host_rvalid_i (host_rvalid), .host_err_i (host_err), .host_rdata_i (host_rdata)
  );

  tb_host_mem host_mem (
    .clk (clk), .rst_n_i (rst_n), .req_i (host_req), .addr_i (host_addr), .we_i (host_we),
    .be_i (host_be), .wdata_i (host_wdata), .gnt_o (host_gnt), .rvalid_o (host_rvalid),
    .err_o (host_err), .rdata_o (host_rdata)
  );

  // limit grows with the job lengths in the stim file
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout after %0d cycles, a bus access or job never completed", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic report_mismatch(input string tname, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    $display("ERROR %s %s expected %h actual %h", tname, what, exp, act);
    errors++;
  endtask

  task automatic finish_test(input string tname, input int errs0);
    tests++;
    if (errors == errs0) begin
      $display("PASS %s", tname);
    end else begin
      failed++;
      $display("FAIL %s", tname);
    end
  endtask

  // one CPU access on the device port and its one-cycle response
  task automatic dev_access(input logic we, input logic [7:0] off, input logic [31:0] wdata,
                            input logic [3:0] be, output logic [31:0] rdata,
                            output logic err);
    @(posedge clk);
    dev_req   <= 1'b1;
    dev_we    <= we;
    dev_addr  <= DEV_BASE | 32'(off);
    dev_be    <= be;
    dev_wdata <= wdata;
    @(posedge clk);
    if (dev_gnt !== 1'b1) begin
      $display("device port gave no grant in the request cycle");
      errors++;
    end
    dev_req <= 1'b0;
    @(posedge clk);
    if (dev_rvalid !== 1'b1) begin
      $display("device port gave no response one cycle after the grant");
      errors++;
    end
    rdata = dev_rdata;
    err   = dev_err;
  endtask

  task automatic load_stim(output bit ok);
    int               fd;
    int               n;
    string            tok;
    string            nm;
    logic [31:0]      v [5];
    logic [8*160-1:0] rest;
    ok = 1'b1;
    fd = $fopen("accel_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open accel_stim.txt");
      ok = 1'b0;
    end else begin
      while (ok && $fscanf(fd, " %s", tok) == 1) begin
        nm = "";
        v  = '{default: '0};
        if (tok == "R") begin
          n = $fscanf(fd, " %h %h %h %h", v[0], v[1], v[2], v[3]) - 4;
        end else if (tok == "X") begin
          n = $fscanf(fd, " %h", v[0]) - 1;
        end else if (tok == "D") begin
          n = $fscanf(fd, " %s %h %h %h %h %h", nm, v[0], v[1], v[2], v[3], v[4]) - 6;
        end else begin
          n   = 0;
          tok = "";
          void'($fgets(rest, fd));  // comment line
        end
        if (n != 0) begin
          $display("stim record %0d could not be parsed", rec_kind.size());
          ok = 1'b0;
        end else if (tok != "") begin
          rec_kind.push_back(tok);
          rec_name.push_back(nm);
          for (int k = 0; k < 5; k++) rec_val.push_back(v[k]);
          if (tok == "D") limit += 60 * int'(v[2]);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_reg(input logic [7:0] off, input logic [31:0] wdata,
                         input logic [3:0] be, input logic [31:0] exp);
    string       tname;
    int          errs0;
    logic [31:0] rd;
    logic        err;
    tname = $sformatf("reg_%h_be%h", off, be);
    errs0 = errors;
    dev_access(1'b1, off, wdata, be, rd, err);
    if (err !== 1'b0) report_mismatch(tname, "write err", 0, err);
    dev_access(1'b0, off, '0, 4'hf, rd, err);
    if (err !== 1'b0) report_mismatch(tname, "read err", 0, err);
    if (rd !== exp) report_mismatch(tname, "readback", exp, rd);
    if (off >= REG_SRC && off <= REG_BIAS && off[1:0] == 2'b00) begin
      reg_model[(off - REG_SRC) >> 2] = exp;
    end
    finish_test(tname, errs0);
  endtask

  task automatic run_unmapped(input logic [7:0] off);
    string       tname;
    int          errs0;
    logic [31:0] rd;
    logic        err;
    tname = $sformatf("unmapped_%h", off);
    errs0 = errors;
    dev_access(1'b1, off, 32'hffff_ffff, 4'hf, rd, err);
    if (err !== 1'b1) report_mismatch(tname, "write err", 1, err);
    if (rd !== 32'h0) report_mismatch(tname, "write rdata", 0, rd);
    dev_access(1'b0, off, '0, 4'hf, rd, err);
    if (err !== 1'b1) report_mismatch(tname, "read err", 1, err);
    if (rd !== 32'h0) report_mismatch(tname, "read rdata", 0, rd);
    for (int k = 0; k < 5; k++) begin
      dev_access(1'b0, REG_SRC + 8'(4 * k), '0, 4'hf, rd, err);
      if (rd !== reg_model[k]) report_mismatch(tname, $sformatf("reg %0d", k), reg_model[k], rd);
    end
    finish_test(tname, errs0);
  endtask

  task automatic run_job(input string tname, input logic [31:0] src, input logic [31:0] dst,
                         input logic [31:0] len, input logic [31:0] scale,
                         input logic [31:0] bias);
    logic [31:0] xs [$];
    logic [31:0] guard;
    logic [31:0] exp;
    logic [31:0] act;
    logic [31:0] rd;
    logic [31:0] st;
    logic        err;
    int          errs0;
    int          wr0;
    errs0 = errors;
    for (int i = 0; i < len; i++) begin
      rng = xorshift32(rng);
      xs.push_back(rng);
      host_mem.poke(src + 32'(4 * i), rng);
    end
    rng   = xorshift32(rng);
    guard = rng;
    host_mem.poke(dst + 4 * len, guard);  // word right after the destination
    dev_access(1'b1, REG_SRC, src, 4'hf, rd, err);
    dev_access(1'b1, REG_DST, dst, 4'hf, rd, err);
    dev_access(1'b1, REG_LEN, len, 4'hf, rd, err);
    dev_access(1'b1, REG_SCALE, scale, 4'hf, rd, err);
    dev_access(1'b1, REG_BIAS, bias, 4'hf, rd, err);
    reg_model = '{src, dst, len, scale, bias};
    wr0 = host_mem.wr_count;
    dev_access(1'b1, REG_CTRL, 32'h1, 4'hf, rd, err);
    if (len != 0) begin
      dev_access(1'b0, REG_STATUS, '0, 4'hf, st, err);
      if (st !== 32'h1) report_mismatch(tname, "status after start", 32'h1, st);
      dev_access(1'b1, REG_CTRL, 32'h1, 4'hf, rd, err);  // second start while busy
    end
    st = 32'h1;
    while (st[STAT_BUSY] !== 1'b0) dev_access(1'b0, REG_STATUS, '0, 4'hf, st, err);
    dev_access(1'b0, REG_STATUS, '0, 4'hf, st, err);
    if (st !== 32'h2) report_mismatch(tname, "final status", 32'h2, st);
    if (host_mem.wr_count - wr0 != len) begin
      report_mismatch(tname, "host writes", len, host_mem.wr_count - wr0);
    end
    for (int i = 0; i < len; i++) begin
      exp = xs[i] * scale + bias;  // wraps mod 2^32
      act = host_mem.peek(dst + 32'(4 * i));
      if (act !== exp) report_mismatch(tname, $sformatf("word %0d", i), exp, act);
    end
    act = host_mem.peek(dst + 4 * len);
    if (act !== guard) report_mismatch(tname, "guard word", guard, act);
    finish_test(tname, errs0);
  endtask

  initial begin
    rng       = 32'he789;
    reg_model = '{default: '0};
    rst_n     <= 1'b0;
    dev_req   <= 1'b0;
    dev_addr  <= '0;
    dev_we    <= 1'b0;
    dev_be    <= '0;
    dev_wdata <= '0;
    load_stim(ok);
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    if (ok) begin
      for (int r = 0; r < rec_kind.size(); r++) begin
        if (rec_kind[r] == "R") begin
          run_reg(rec_val[5*r][7:0], rec_val[5*r+1], rec_val[5*r+2][3:0], rec_val[5*r+3]);
        end else if (rec_kind[r] == "X") begin
          run_unmapped(rec_val[5*r][7:0]);
        end else begin
          run_job(rec_name[r], rec_val[5*r], rec_val[5*r+1], rec_val[5*r+2],
                  rec_val[5*r+3], rec_val[5*r+4]);
        end
      end
    end else begin
      errors++;
    end
    $display("tests %0d passed %0d failed %0d errors %0d", tests, tests - failed, failed, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- tb_host_mem.sv
module tb_host_mem (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  input  logic        we_i,
  input  logic [3:0]  be_i,
  input  logic [31:0] wdata_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic        err_o,
  output logic [31:0] rdata_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] mem [logic [29:0]];  // sparse, indexed by word address
  logic [31:0] rng;
  logic [1:0]  gnt_wait;            // cycles left before the next grant
  logic [31:0] word;
  int          cyc;
  int          due;
  int          last_due;
  int          wr_count;            // granted writes, read by the testbench
  logic [31:0] resp_data [$];
  int          resp_due [$];

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // untouched words read back as the inverted address
  function automatic logic [31:0] peek(input logic [31:0] addr);
    if (mem.exists(addr[31:2])) return mem[addr[31:2]];
    return ~addr;
  endfunction

  function automatic void poke(input logic [31:0] addr, input logic [31:0] data);
    mem[addr[31:2]] = data;
  endfunction

  assign gnt_o = req_i && (gnt_wait == 2'd0);
  assign err_o = 1'b0;

  initial begin
    rng      = 32'he789;
    gnt_wait = '0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    cyc      = 0;
    last_due = 0;
    wr_count = 0;
  end

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (!rst_n_i) begin
      rng      = 32'he789;
      last_due = 0;
      gnt_wait <= '0;
      rvalid_o <= 1'b0;
      resp_data.delete();
      resp_due.delete();
    end else begin
      if (gnt_o) begin
        rng = xorshift32(rng);
        gnt_wait <= rng[1:0];  // 0..3 cycles until the next grant
        word = peek(addr_i);
        if (we_i) begin
          for (int b = 0; b < 4; b++) begin
            if (be_i[b]) word[8*b +: 8] = wdata_i[8*b +: 8];
          end
          mem[addr_i[31:2]] = word;
          wr_count = wr_count + 1;
        end
        resp_data.push_back(we_i ? 32'h0 : word);
        due = cyc + int'(rng[9:8]) % 3;  // answer 1..3 cycles after the grant
        if (due <= last_due) due = last_due + 1;  // keep responses in order
        last_due = due;
        resp_due.push_back(due);
      end else if (req_i && gnt_wait != 2'd0) begin
        gnt_wait <= gnt_wait - 1'b1;
      end
      rvalid_o <= 1'b0;
      if (resp_due.size() != 0 && resp_due[0] <= cyc) begin
        rvalid_o <= 1'b1;
        rdata_o  <= resp_data.pop_front();
        void'(resp_due.pop_front());
      end
    end
  end

endmodule
